// File: rtl/tlb_entry_pkg.sv
package tlb_entry_pkg;

    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = 4;

    // bit 0 of a vpn picks the odd page of a pair
    localparam int vpn_w       = 20;
    localparam int vppn_w      = 19;
    localparam int asid_w      = 10;
    localparam int ppn_w       = 20;
    localparam int plv_w       = 2;
    localparam int mat_w       = 2;
    localparam int page_lo_w   = 28;

    // page-lo word: ppn 27:8, bit 7 reserved, g 6, mat 5:4, plv 3:2, d 1, v 0
    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic             rsv;
        logic             g;
        logic [mat_w-1:0] mat;
        logic [plv_w-1:0] plv;
        logic             d;
        logic             v;
    } page_lo_t;

    // g is kept in both lo words, always equal after a write
    typedef struct packed {
        logic [vppn_w-1:0] vppn;
        logic              ps_huge;
        logic [asid_w-1:0] asid;
        logic              e;
        page_lo_t          lo0;
        page_lo_t          lo1;
    } tlb_entry_t;

endpackage

// File: rtl/tlb_op_pkg.sv
package tlb_op_pkg;

    localparam int inv_op_w = 5;
    localparam int ps_w     = 6;

    // invtlb operation codes
    typedef enum logic [inv_op_w-1:0] {
        inv_all0         = 5'd0,
        inv_all1         = 5'd1,
        inv_global       = 5'd2,
        inv_nonglobal    = 5'd3,
        inv_asid         = 5'd4,
        inv_asid_va      = 5'd5,
        inv_g_or_asid_va = 5'd6
    } inv_op_t;

    // page sizes as log2 of the byte count
    localparam logic [ps_w-1:0] ps_4k        = 6'd12;
    localparam logic [ps_w-1:0] ps_huge_code = 6'd21;

endpackage

// File: rtl/tlb_stage_if.sv
`timescale 1ns/1ps

interface tlb_stage_if;

    logic                                hit;
    logic [tlb_entry_pkg::tlb_idx_w-1:0] idx;
    logic                                odd;
    logic [tlb_entry_pkg::plv_w-1:0]     priv;

    modport match (
        output hit,
        output idx,
        output odd,
        output priv
    );

    modport check (
        input  hit,
        input  idx,
        input  odd,
        input  priv
    );

endinterface

// File: rtl/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic                                    clock,
    input  logic                                    rst_n,

    input  logic                                    w_en,
    input  logic [tlb_entry_pkg::tlb_idx_w-1:0]     w_idx,
    input  logic [tlb_entry_pkg::vppn_w-1:0]        w_vppn,
    input  logic [tlb_op_pkg::ps_w-1:0]             w_ps,
    input  logic [tlb_entry_pkg::asid_w-1:0]        w_asid,
    input  logic                                    w_e,
    input  tlb_entry_pkg::page_lo_t                 w_lo0,
    input  tlb_entry_pkg::page_lo_t                 w_lo1,

    input  logic                                    inv_en,
    input  logic [tlb_entry_pkg::tlb_entries-1:0]   kill_mask,

    input  logic [tlb_entry_pkg::tlb_idx_w-1:0]     r_idx,
    output tlb_entry_pkg::tlb_entry_t               r_entry,

    output tlb_entry_pkg::tlb_entry_t               entries [tlb_entry_pkg::tlb_entries]
);

    logic [tlb_entry_pkg::tlb_entries-1:0] e_q;

    logic [tlb_entry_pkg::vppn_w-1:0] vppn_q    [tlb_entry_pkg::tlb_entries];
    logic                             ps_huge_q [tlb_entry_pkg::tlb_entries];
    logic [tlb_entry_pkg::asid_w-1:0] asid_q    [tlb_entry_pkg::tlb_entries];
    tlb_entry_pkg::page_lo_t          lo0_q     [tlb_entry_pkg::tlb_entries];
    tlb_entry_pkg::page_lo_t          lo1_q     [tlb_entry_pkg::tlb_entries];

    logic                    w_g;
    tlb_entry_pkg::page_lo_t w_lo0_g;
    tlb_entry_pkg::page_lo_t w_lo1_g;
    logic                    wr_fire;

    // an entry is global only if both halves say so
    assign w_g = w_lo0.g & w_lo1.g;

    always_comb begin
        w_lo0_g   = w_lo0;
        w_lo1_g   = w_lo1;
        w_lo0_g.g = w_g;
        w_lo1_g.g = w_g;
    end

    // invalidate beats write
    assign wr_fire = w_en & ~inv_en;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (inv_en) begin
            e_q <= e_q & ~kill_mask;
        end else if (w_en) begin
            e_q[w_idx] <= w_e;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            vppn_q[w_idx]    <= w_vppn;
            ps_huge_q[w_idx] <= (w_ps == tlb_op_pkg::ps_huge_code);
            asid_q[w_idx]    <= w_asid;
            lo0_q[w_idx]     <= w_lo0_g;
            lo1_q[w_idx]     <= w_lo1_g;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entry_pkg::tlb_entries; i++) begin
            entries[i].vppn    = vppn_q[i];
            entries[i].ps_huge = ps_huge_q[i];
            entries[i].asid    = asid_q[i];
            entries[i].e       = e_q[i];
            entries[i].lo0     = lo0_q[i];
            entries[i].lo1     = lo1_q[i];
        end
    end

    assign r_entry = entries[r_idx];

endmodule

// File: rtl/tlb_inv_match.sv
`timescale 1ns/1ps

module tlb_inv_match (
    input  tlb_op_pkg::inv_op_t                     inv_op,
    input  logic [tlb_entry_pkg::asid_w-1:0]        inv_asid,
    input  logic [tlb_entry_pkg::vpn_w-1:0]         inv_vpn,
    input  tlb_entry_pkg::tlb_entry_t               entries [tlb_entry_pkg::tlb_entries],
    output logic [tlb_entry_pkg::tlb_entries-1:0]   kill_mask
);

    always_comb begin
        logic g;
        logic asid_eq;
        logic va_eq;

        kill_mask = '0;
        for (int i = 0; i < tlb_entry_pkg::tlb_entries; i++) begin
            g       = entries[i].lo0.g;
            asid_eq = (entries[i].asid == inv_asid);
            // the pair number ignores the odd-page bit
            va_eq   = (entries[i].vppn == inv_vpn[tlb_entry_pkg::vpn_w-1:1]);
            case (inv_op)
                tlb_op_pkg::inv_all0,
                tlb_op_pkg::inv_all1: begin
                    kill_mask[i] = 1'b1;
                end
                tlb_op_pkg::inv_global:       kill_mask[i] = g;
                tlb_op_pkg::inv_nonglobal:    kill_mask[i] = ~g;
                tlb_op_pkg::inv_asid:         kill_mask[i] = ~g & asid_eq;
                tlb_op_pkg::inv_asid_va:      kill_mask[i] = ~g & asid_eq & va_eq;
                tlb_op_pkg::inv_g_or_asid_va: kill_mask[i] = (g | asid_eq) & va_eq;
                // codes 7 and up do nothing
                default:                      kill_mask[i] = 1'b0;
            endcase
        end
    end

endmodule

// File: rtl/tlb_match_stage.sv
`timescale 1ns/1ps

module tlb_match_stage (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [tlb_entry_pkg::vpn_w-1:0]     vpn,
    input  logic [tlb_entry_pkg::asid_w-1:0]    asid,
    input  logic [tlb_entry_pkg::plv_w-1:0]     priv,
    input  tlb_entry_pkg::tlb_entry_t           entries [tlb_entry_pkg::tlb_entries],
    tlb_stage_if.match                          res
);

    logic [tlb_entry_pkg::tlb_entries-1:0] hit_vec;
    logic [tlb_entry_pkg::tlb_idx_w-1:0]   hit_idx;

    logic                                  hit_q;
    logic [tlb_entry_pkg::tlb_idx_w-1:0]   idx_q;
    logic                                  odd_q;
    logic [tlb_entry_pkg::plv_w-1:0]       priv_q;

    always_comb begin
        for (int i = 0; i < tlb_entry_pkg::tlb_entries; i++) begin
            hit_vec[i] = entries[i].e
                && (entries[i].vppn == vpn[tlb_entry_pkg::vpn_w-1:1])
                && (entries[i].lo0.g || (entries[i].asid == asid));
        end
    end

    // scan downward so the lowest hit is the last one kept
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_entry_pkg::tlb_entries - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = (tlb_entry_pkg::tlb_idx_w)'(i);
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= |hit_vec;
        end
    end

    always_ff @(posedge clock) begin
        idx_q  <= hit_idx;
        odd_q  <= vpn[0];
        priv_q <= priv;
    end

    assign res.hit  = hit_q;
    assign res.idx  = idx_q;
    assign res.odd  = odd_q;
    assign res.priv = priv_q;

endmodule

// File: rtl/tlb_page_check_stage.sv
`timescale 1ns/1ps

module tlb_page_check_stage (
    tlb_stage_if.check                          req,
    input  tlb_entry_pkg::tlb_entry_t           entries [tlb_entry_pkg::tlb_entries],
    output logic [tlb_entry_pkg::tlb_idx_w-1:0] idx,
    output logic                                valid,
    output logic                                unpriv,
    output logic [tlb_entry_pkg::ppn_w-1:0]     ppn,
    output logic                                uncached
);

    tlb_entry_pkg::tlb_entry_t hit_entry;
    tlb_entry_pkg::page_lo_t   page;

    // contents as they stand now, so a write last edge is seen
    assign hit_entry = entries[req.idx];
    assign page      = req.odd ? hit_entry.lo1 : hit_entry.lo0;

    assign idx      = req.idx;
    assign valid    = req.hit & page.v;
    assign unpriv   = (page.plv < req.priv);
    assign ppn      = page.ppn;
    // mat 0 is strongly-ordered uncached
    assign uncached = (page.mat == '0);

endmodule

// File: rtl/tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
    input  logic                                clock,
    input  logic                                rst_n,

    // instruction fetch, result one clock later
    input  logic [tlb_entry_pkg::vpn_w-1:0]     if_vpn,
    input  logic [tlb_entry_pkg::asid_w-1:0]    if_asid,
    input  logic [tlb_entry_pkg::plv_w-1:0]     if_priv,
    output logic [tlb_entry_pkg::tlb_idx_w-1:0] if_idx,
    output logic                                if_valid,
    output logic                                if_unpriv,
    output logic [tlb_entry_pkg::ppn_w-1:0]     if_ppn,
    output logic                                if_uncached,

    // load / store
    input  logic [tlb_entry_pkg::vpn_w-1:0]     ls_vpn,
    input  logic [tlb_entry_pkg::asid_w-1:0]    ls_asid,
    input  logic [tlb_entry_pkg::plv_w-1:0]     ls_priv,
    output logic [tlb_entry_pkg::tlb_idx_w-1:0] ls_idx,
    output logic                                ls_valid,
    output logic                                ls_unpriv,
    output logic [tlb_entry_pkg::ppn_w-1:0]     ls_ppn,
    output logic                                ls_uncached,

    input  logic                                w_en,
    input  logic [tlb_entry_pkg::tlb_idx_w-1:0] w_idx,
    input  logic [tlb_entry_pkg::vppn_w-1:0]    w_vppn,
    input  logic [tlb_op_pkg::ps_w-1:0]         w_ps,
    input  logic [tlb_entry_pkg::asid_w-1:0]    w_asid,
    input  logic                                w_e,
    input  logic [tlb_entry_pkg::page_lo_w-1:0] w_tlbelo0,
    input  logic [tlb_entry_pkg::page_lo_w-1:0] w_tlbelo1,

    // combinational read
    input  logic [tlb_entry_pkg::tlb_idx_w-1:0] r_idx,
    output logic [tlb_entry_pkg::vppn_w-1:0]    r_vppn,
    output logic [tlb_entry_pkg::asid_w-1:0]    r_asid,
    output logic [tlb_op_pkg::ps_w-1:0]         r_ps,
    output logic                                r_e,
    output logic [tlb_entry_pkg::page_lo_w-1:0] r_tlbelo0,
    output logic [tlb_entry_pkg::page_lo_w-1:0] r_tlbelo1,

    input  logic                                inv_en,
    input  logic [tlb_op_pkg::inv_op_w-1:0]     inv_op,
    input  logic [tlb_entry_pkg::asid_w-1:0]    inv_asid,
    input  logic [tlb_entry_pkg::vpn_w-1:0]     inv_vpn
);

    tlb_entry_pkg::tlb_entry_t             entries [tlb_entry_pkg::tlb_entries];
    tlb_entry_pkg::tlb_entry_t             r_entry;
    logic [tlb_entry_pkg::tlb_entries-1:0] kill_mask;

    tlb_stage_if if_stage ();
    tlb_stage_if ls_stage ();

    tlb_entry_array i_entry_array (
        .clock     (clock),
        .rst_n     (rst_n),
        .w_en      (w_en),
        .w_idx     (w_idx),
        .w_vppn    (w_vppn),
        .w_ps      (w_ps),
        .w_asid    (w_asid),
        .w_e       (w_e),
        .w_lo0     (tlb_entry_pkg::page_lo_t'(w_tlbelo0)),
        .w_lo1     (tlb_entry_pkg::page_lo_t'(w_tlbelo1)),
        .inv_en    (inv_en),
        .kill_mask (kill_mask),
        .r_idx     (r_idx),
        .r_entry   (r_entry),
        .entries   (entries)
    );

    tlb_inv_match i_inv_match (
        .inv_op    (tlb_op_pkg::inv_op_t'(inv_op)),
        .inv_asid  (inv_asid),
        .inv_vpn   (inv_vpn),
        .entries   (entries),
        .kill_mask (kill_mask)
    );

    tlb_match_stage i_if_match (
        .clock   (clock),
        .rst_n   (rst_n),
        .vpn     (if_vpn),
        .asid    (if_asid),
        .priv    (if_priv),
        .entries (entries),
        .res     (if_stage.match)
    );

    tlb_page_check_stage i_if_check (
        .req      (if_stage.check),
        .entries  (entries),
        .idx      (if_idx),
        .valid    (if_valid),
        .unpriv   (if_unpriv),
        .ppn      (if_ppn),
        .uncached (if_uncached)
    );

    tlb_match_stage i_ls_match (
        .clock   (clock),
        .rst_n   (rst_n),
        .vpn     (ls_vpn),
        .asid    (ls_asid),
        .priv    (ls_priv),
        .entries (entries),
        .res     (ls_stage.match)
    );

    tlb_page_check_stage i_ls_check (
        .req      (ls_stage.check),
        .entries  (entries),
        .idx      (ls_idx),
        .valid    (ls_valid),
        .unpriv   (ls_unpriv),
        .ppn      (ls_ppn),
        .uncached (ls_uncached)
    );

    assign r_vppn    = r_entry.vppn;
    assign r_asid    = r_entry.asid;
    assign r_e       = r_entry.e;
    assign r_tlbelo0 = r_entry.lo0;
    assign r_tlbelo1 = r_entry.lo1;
    // only two page sizes are stored
    assign r_ps      = r_entry.ps_huge ? tlb_op_pkg::ps_huge_code : tlb_op_pkg::ps_4k;

endmodule

// File: verif/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

    localparam logic [3:0] k_write  = 4'b0001;
    localparam logic [3:0] k_inv    = 4'b0010;
    localparam logic [3:0] k_lookup = 4'b0100;
    localparam logic [3:0] k_read   = 4'b1000;

    typedef struct {
        logic [3:0]  kind;
        logic [3:0]  idx;
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        e;
        logic [27:0] lo0;
        logic [27:0] lo1;
        logic [4:0]  op;
        logic [19:0] vpn;
        logic [1:0]  priv;
    } step_t;

    logic        clock = 1'b0;
    logic        rst_n;
    logic [19:0] if_vpn, ls_vpn, inv_vpn, if_ppn, ls_ppn;
    logic [9:0]  if_asid, ls_asid, w_asid, inv_asid, r_asid;
    logic [1:0]  if_priv, ls_priv;
    logic [3:0]  if_idx, ls_idx, w_idx, r_idx;
    logic        if_valid, if_unpriv, if_uncached;
    logic        ls_valid, ls_unpriv, ls_uncached;
    logic        w_en, w_e, inv_en, r_e;
    logic [18:0] w_vppn, r_vppn;
    logic [5:0]  w_ps, r_ps;
    logic [27:0] w_tlbelo0, w_tlbelo1, r_tlbelo0, r_tlbelo1;
    logic [4:0]  inv_op;

    tlb_entry_pkg::tlb_entry_t model [16];
    step_t      steps [$];
    int         errors = 0;
    int         cycles = 0;
    int         max_cycles = 20;
    logic       pend = 1'b0;
    logic       pend_hit [2];
    logic [3:0] pend_idx [2];
    logic       pend_odd [2];
    logic [1:0] pend_priv;

    tlb_top i_tlb_top (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run did not end within %0d cycles, %0d errors", max_cycles, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic step_t row(input logic [3:0] kind, input logic [3:0] idx,
                                  input logic [18:0] vppn, input logic [9:0] asid,
                                  input logic [5:0] ps, input logic e,
                                  input logic [27:0] lo0, input logic [27:0] lo1,
                                  input logic [4:0] op, input logic [19:0] vpn,
                                  input logic [1:0] priv);
        step_t s;
        s = '{kind, idx, vppn, asid, ps, e, lo0, lo1, op, vpn, priv};
        return s;
    endfunction

    // d set, reserved bit clear
    function automatic logic [27:0] page_lo(input logic [19:0] ppn, input logic g,
                                            input logic [1:0] mat, input logic [1:0] plv,
                                            input logic v);
        return {ppn, 1'b0, g, mat, plv, 1'b1, v};
    endfunction

    // lowest enabled entry with the same pair, global or same asid
    function automatic logic [4:0] model_match(input logic [19:0] vpn, input logic [9:0] asid);
        logic [4:0] res;
        res = 5'd0;
        for (int i = 15; i >= 0; i--) begin
            if (model[i].e && model[i].vppn == vpn[19:1]
                    && (model[i].lo0.g || model[i].asid == asid)) begin
                res = {1'b1, i[3:0]};
            end
        end
        return res;
    endfunction

    function automatic logic model_kill(input int i, input logic [4:0] op,
                                        input logic [9:0] asid, input logic [19:0] vpn);
        logic g;
        logic a;
        logic v;
        g = model[i].lo0.g;
        a = (model[i].asid == asid);
        v = (model[i].vppn == vpn[19:1]);
        case (op)
            tlb_op_pkg::inv_all0,
            tlb_op_pkg::inv_all1:         return 1'b1;
            tlb_op_pkg::inv_global:       return g;
            tlb_op_pkg::inv_nonglobal:    return !g;
            tlb_op_pkg::inv_asid:         return !g && a;
            tlb_op_pkg::inv_asid_va:      return !g && a && v;
            tlb_op_pkg::inv_g_or_asid_va: return (g || a) && v;
            default:                      return 1'b0;
        endcase
    endfunction

    task automatic apply_model(input step_t s);
        tlb_entry_pkg::page_lo_t lo0;
        tlb_entry_pkg::page_lo_t lo1;
        lo0   = s.lo0;
        lo1   = s.lo1;
        lo0.g = lo0.g & lo1.g;
        lo1.g = lo0.g;
        // write is lost when an invalidate comes in the same cycle
        if ((s.kind & k_inv) != 0) begin
            for (int i = 0; i < 16; i++) begin
                if (model_kill(i, s.op, s.asid, s.vpn))
                    model[i].e = 1'b0;
            end
        end else if ((s.kind & k_write) != 0) begin
            model[s.idx] = '{s.vppn, s.ps == 6'd21, s.asid, s.e, lo0, lo1};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_port(input int p, input logic [3:0] idx, input logic valid,
                              input logic unpriv, input logic [19:0] ppn, input logic uncached);
        tlb_entry_pkg::page_lo_t page;
        string pfx;
        pfx = (p == 0) ? "if_" : "ls_";
        if (!pend_hit[p]) begin
            check_val({pfx, "valid"}, valid, 0);
        end else begin
            page = pend_odd[p] ? model[pend_idx[p]].lo1 : model[pend_idx[p]].lo0;
            check_val({pfx, "valid"}, valid, page.v);
            check_val({pfx, "idx"}, idx, pend_idx[p]);
            check_val({pfx, "unpriv"}, unpriv, page.plv < pend_priv);
            check_val({pfx, "ppn"}, ppn, page.ppn);
            check_val({pfx, "uncached"}, uncached, page.mat == 2'd0);
        end
    endtask

    task automatic check_pending();
        if (pend) begin
            check_port(0, if_idx, if_valid, if_unpriv, if_ppn, if_uncached);
            check_port(1, ls_idx, ls_valid, ls_unpriv, ls_ppn, ls_uncached);
        end
        pend = 1'b0;
    endtask

    task automatic check_read(input logic [3:0] idx);
        check_val("r_vppn", r_vppn, model[idx].vppn);
        check_val("r_asid", r_asid, model[idx].asid);
        check_val("r_ps", r_ps, model[idx].ps_huge ? 6'd21 : 6'd12);
        check_val("r_e", r_e, model[idx].e);
        check_val("r_tlbelo0", r_tlbelo0, model[idx].lo0);
        check_val("r_tlbelo1", r_tlbelo1, model[idx].lo1);
    endtask

    task automatic drive_inputs(input step_t s);
        w_en      = (s.kind & k_write) != 0;
        inv_en    = (s.kind & k_inv) != 0;
        w_idx     = s.idx;
        w_vppn    = s.vppn;
        w_ps      = s.ps;
        w_asid    = s.asid;
        w_e       = s.e;
        w_tlbelo0 = s.lo0;
        w_tlbelo1 = s.lo1;
        inv_op    = s.op;
        inv_asid  = s.asid;
        inv_vpn   = s.vpn;
        r_idx     = s.idx;
        if_vpn    = s.vpn;
        if_asid   = s.asid;
        if_priv   = s.priv;
        // ls port looks up the other half of the pair
        ls_vpn    = {s.vpn[19:1], ~s.vpn[0]};
        ls_asid   = s.asid;
        ls_priv   = s.priv;
    endtask

    task automatic run_step(input step_t s);
        @(posedge clock);
        #1;
        check_pending();
        drive_inputs(s);
        if ((s.kind & k_lookup) != 0) begin
            // hit decided on contents before the sampling edge
            {pend_hit[0], pend_idx[0]} = model_match(if_vpn, s.asid);
            {pend_hit[1], pend_idx[1]} = model_match(ls_vpn, s.asid);
            pend_odd[0] = if_vpn[0];
            pend_odd[1] = ls_vpn[0];
            pend_priv   = s.priv;
            pend        = 1'b1;
        end
        if ((s.kind & k_read) != 0) begin
            #1;
            check_read(s.idx);
        end
        apply_model(s);
    endtask

    task automatic build_table();
        logic [31:0] r0;
        logic [31:0] r1;
        // nothing enabled yet
        steps.push_back(row(k_lookup, 0, 0, 10'h005, 0, 0, 0, 0, 0, 20'h00020, 2'd0));
        steps.push_back(row(k_lookup, 0, 0, 10'h000, 0, 0, 0, 0, 0, 20'h00041, 2'd3));
        steps.push_back(row(k_write, 4'd0, 19'h00010, 10'h005, 6'd12, 1'b1,
            page_lo(20'h12340, 1, 2'd1, 2'd0, 1), page_lo(20'h56780, 0, 2'd0, 2'd3, 1), 0, 0, 0));
        steps.push_back(row(k_write, 4'd1, 19'h00020, 10'h006, 6'd21, 1'b1,
            page_lo(20'haaaa0, 1, 2'd1, 2'd2, 1), page_lo(20'hbbbb0, 1, 2'd0, 2'd1, 0), 0, 0, 0));
        steps.push_back(row(k_write, 4'd2, 19'h00030, 10'h007, 6'd12, 1'b0,
            page_lo(20'h33330, 0, 2'd1, 2'd0, 1), page_lo(20'h44440, 0, 2'd1, 2'd0, 1), 0, 0, 0));
        steps.push_back(row(k_write, 4'd3, 19'h7ffff, 10'h3ff, 6'd21, 1'b1,
            page_lo(20'h00001, 0, 2'd1, 2'd0, 0), page_lo(20'hfffff, 0, 2'd2, 2'd1, 1), 0, 0, 0));
        for (int i = 0; i < 4; i++)
            steps.push_back(row(k_read, i[3:0], 0, 0, 0, 0, 0, 0, 0, 0, 0));
        // back to back lookups on both ports
        steps.push_back(row(k_lookup, 0, 0, 10'h005, 0, 0, 0, 0, 0, 20'h00020, 2'd0));
        steps.push_back(row(k_lookup, 0, 0, 10'h005, 0, 0, 0, 0, 0, 20'h00021, 2'd3));
        steps.push_back(row(k_lookup, 0, 0, 10'h009, 0, 0, 0, 0, 0, 20'h00020, 2'd0));
        steps.push_back(row(k_lookup, 0, 0, 10'h3ff, 0, 0, 0, 0, 0, 20'h00040, 2'd3));
        steps.push_back(row(k_lookup, 0, 0, 10'h007, 0, 0, 0, 0, 0, 20'h00061, 2'd0));
        steps.push_back(row(k_lookup, 0, 0, 10'h3ff, 0, 0, 0, 0, 0, 20'hfffff, 2'd2));
        steps.push_back(row(k_lookup, 0, 0, 10'h123, 0, 0, 0, 0, 0, 20'h00041, 2'd1));
        steps.push_back(row(k_lookup, 0, 0, 10'h3fe, 0, 0, 0, 0, 0, 20'hffffe, 2'd0));
        // fresh random population per invalidate code, then read every entry
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 16; i++) begin
                r0 = $urandom;
                r1 = $urandom;
                steps.push_back(row(k_write, i[3:0], 19'h00100 + r0[27:26],
                    r0[28] ? 10'h011 : 10'h022, r0[29] ? 6'd21 : 6'd12, r0[31:30] != 2'd0,
                    page_lo(r0[19:0], r0[20], r0[22:21], r0[24:23], 1'b1),
                    page_lo(r1[19:0], r1[20], r1[22:21], r1[24:23], r1[25]), 0, 0, 0));
            end
            r0 = $urandom;
            steps.push_back(row(k_inv, 0, 0, 10'h011, 0, 0, 0, 0, op[4:0],
                {19'h00101, r0[0]}, 0));
            for (int i = 0; i < 16; i++)
                steps.push_back(row(k_read, i[3:0], 0, 0, 0, 0, 0, 0, 0, 0, 0));
        end
        // invalidate all together with a write to entry 5
        steps.push_back(row(k_inv | k_write, 4'd5, 19'h55555, 10'h2aa, 6'd21, 1'b1,
            page_lo(20'h55555, 1, 2'd3, 2'd3, 1), page_lo(20'h66666, 1, 2'd3, 2'd3, 1), 0, 0, 0));
        steps.push_back(row(k_read, 4'd5, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        steps.push_back(row(k_read, 4'd4, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        // rewrite an entry at the edge where its lookup is sampled
        steps.push_back(row(k_write, 4'd0, 19'h00040, 10'h005, 6'd12, 1'b1,
            page_lo(20'h11111, 0, 2'd1, 2'd0, 1), page_lo(20'h11112, 0, 2'd1, 2'd0, 1), 0, 0, 0));
        steps.push_back(row(k_lookup, 0, 0, 10'h005, 0, 0, 0, 0, 0, 20'h00080, 2'd0));
        steps.push_back(row(k_write | k_lookup, 4'd0, 19'h00040, 10'h005, 6'd12, 1'b1,
            page_lo(20'h22222, 0, 2'd0, 2'd3, 1), page_lo(20'h22223, 0, 2'd0, 2'd1, 1),
            0, 20'h00080, 2'd2));
        steps.push_back(row(k_lookup | k_read, 4'd0, 0, 10'h005, 0, 0, 0, 0, 0, 20'h00081, 2'd3));
    endtask

    initial begin
        logic [31:0] seed_val;
        step_t nop;
        seed_val = $urandom(72137);
        nop = '{default: '0};
        drive_inputs(nop);
        rst_n = 1'b0;
        for (int i = 0; i < 16; i++)
            model[i].e = 1'b0;
        build_table();
        max_cycles = 2 * steps.size() + 20;
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;
        foreach (steps[n])
            run_step(steps[n]);
        @(posedge clock);
        #1;
        check_pending();
        $display("%0d steps run, %0d errors", steps.size(), errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/tlb_entry_pkg.sv
rtl/tlb_op_pkg.sv
rtl/tlb_stage_if.sv
rtl/tlb_entry_array.sv
rtl/tlb_inv_match.sv
rtl/tlb_match_stage.sv
rtl/tlb_page_check_stage.sv
rtl/tlb_top.sv
verif/tlb_tb.sv

// File: Bender.yml
package:
  name: tlb

sources:
  - rtl/tlb_entry_pkg.sv
  - rtl/tlb_op_pkg.sv
  - rtl/tlb_stage_if.sv
  - rtl/tlb_entry_array.sv
  - rtl/tlb_inv_match.sv
  - rtl/tlb_match_stage.sv
  - rtl/tlb_page_check_stage.sv
  - rtl/tlb_top.sv
  - target: test
    files:
      - verif/tlb_tb.sv
